// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_width = 5;
	localparam int beat_bytes = 8;
	localparam int beat_width = beat_bytes * 8;
	localparam int beat_offset_width = $clog2(beat_bytes);

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_eq,
		alu_ne,
		alu_ge,
		alu_geu
	} alu_op_t;

	typedef enum logic [3:0] {
		mem_none,
		mem_lb,
		mem_lbu,
		mem_lh,
		mem_lhu,
		mem_lw,
		mem_sb,
		mem_sh,
		mem_sw
	} mem_op_t;

	typedef enum logic [1:0] {
		jump_none,
		jump_jal,
		jump_jalr
	} jump_kind_t;

	// one memory beat, as byte lanes or as two words
	typedef union packed {
		logic [beat_bytes-1:0][7:0] lanes;
		logic [1:0][xlen-1:0] halves;
	} beat_u;

	// read FSM states
	localparam logic [1:0] rd_idle = 2'd0;
	localparam logic [1:0] rd_addr = 2'd1;
	localparam logic [1:0] rd_data = 2'd2;
	localparam logic [1:0] rd_second = 2'd3;

	// write FSM states
	localparam logic [2:0] wr_idle = 3'd0;
	localparam logic [2:0] wr_addr = 3'd1;
	localparam logic [2:0] wr_data = 3'd2;
	localparam logic [2:0] wr_resp = 3'd3;
	localparam logic [2:0] wr_second = 3'd4;

	function automatic logic is_load(mem_op_t op);
		return op inside {mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw};
	endfunction

	function automatic logic is_store(mem_op_t op);
		return op inside {mem_sb, mem_sh, mem_sw};
	endfunction

endpackage

`default_nettype wire

// ==== rtl/exu_alu.sv ====
`default_nettype none

module exu_alu (
	input wire exu_pkg::alu_op_t alu_op,
	input wire [exu_pkg::xlen-1:0] src1,
	input wire [exu_pkg::xlen-1:0] src2,
	output logic [exu_pkg::xlen-1:0] result
);
	import exu_pkg::*;

	logic [$clog2(xlen)-1:0] shamt;
	logic lt;
	logic ltu;
	logic eq;

	assign shamt = src2[$clog2(xlen)-1:0];
	assign lt = $signed(src1) < $signed(src2);
	assign ltu = src1 < src2;
	assign eq = src1 == src2;

	always_comb begin
		case (alu_op)
			alu_add: result = src1 + src2;
			alu_sub: result = src1 - src2;
			alu_and: result = src1 & src2;
			alu_or: result = src1 | src2;
			alu_xor: result = src1 ^ src2;
			alu_sll: result = src1 << shamt;
			alu_srl: result = src1 >> shamt;
			alu_sra: result = $signed(src1) >>> shamt;
			// compares land in bit 0
			alu_slt: result = {{(xlen-1){1'b0}}, lt};
			alu_sltu: result = {{(xlen-1){1'b0}}, ltu};
			alu_eq: result = {{(xlen-1){1'b0}}, eq};
			alu_ne: result = {{(xlen-1){1'b0}}, !eq};
			alu_ge: result = {{(xlen-1){1'b0}}, !lt};
			alu_geu: result = {{(xlen-1){1'b0}}, !ltu};
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/store_align.sv ====
`default_nettype none

module store_align (
	input wire exu_pkg::mem_op_t mem_op,
	input wire [exu_pkg::xlen-1:0] addr,
	input wire [exu_pkg::xlen-1:0] store_data,
	input wire second_beat,
	output logic [exu_pkg::xlen-1:0] awaddr,
	output logic [exu_pkg::beat_width-1:0] wdata,
	output logic [exu_pkg::beat_bytes-1:0] wstrb,
	output logic need_second_wr
);
	import exu_pkg::*;

	logic [beat_offset_width-1:0] offset;
	logic [beat_offset_width-1:0] size;
	logic [xlen/8-1:0][7:0] st_bytes;
	logic [xlen-1:0] base;
	beat_u wdata_beat;

	assign offset = addr[beat_offset_width-1:0];
	assign st_bytes = store_data;
	assign base = {addr[xlen-1:beat_offset_width], {beat_offset_width{1'b0}}};
	assign awaddr = second_beat ? base + xlen'(beat_bytes) : base;

	always_comb begin
		case (mem_op)
			mem_sb: size = 1;
			mem_sh: size = 2;
			mem_sw: size = 4;
			default: size = 0;
		endcase
	end

	// crossing into the next beat
	assign need_second_wr = ({1'b0, offset} + {1'b0, size}) > (beat_offset_width+1)'(beat_bytes);

	// pos is the byte position over both beats, rel the store byte it carries
	always_comb begin
		logic [beat_offset_width:0] pos;
		logic [beat_offset_width:0] rel;
		wdata_beat = '0;
		wstrb = '0;
		for (int i = 0; i < beat_bytes; i++) begin
			pos = (beat_offset_width+1)'(i) + (second_beat ? (beat_offset_width+1)'(beat_bytes) : '0);
			rel = pos - {1'b0, offset};
			if (pos >= {1'b0, offset} && rel < {1'b0, size}) begin
				wdata_beat.lanes[i] = st_bytes[rel[1:0]];
				wstrb[i] = 1'b1;
			end
		end
	end

	assign wdata = wdata_beat;

endmodule

`default_nettype wire

// ==== rtl/load_align.sv ====
`default_nettype none

module load_align (
	input wire clock,
	input wire reset,
	input wire exu_pkg::mem_op_t mem_op,
	input wire [exu_pkg::xlen-1:0] addr,
	input wire second_beat,
	input wire capture_beat,
	input wire [exu_pkg::beat_width-1:0] rdata,
	output logic [exu_pkg::xlen-1:0] araddr,
	output logic need_second_rd,
	output logic [exu_pkg::xlen-1:0] load_data
);
	import exu_pkg::*;

	logic [beat_offset_width-1:0] offset;
	logic [beat_offset_width-1:0] size;
	logic [xlen-1:0] base;
	beat_u beat_lo;
	beat_u beat_hi;
	logic [beat_width+xlen-1:0] window;
	logic [beat_width+xlen-1:0] shifted;
	logic [xlen-1:0] raw;

	assign offset = addr[beat_offset_width-1:0];
	assign base = {addr[xlen-1:beat_offset_width], {beat_offset_width{1'b0}}};
	assign araddr = second_beat ? base + xlen'(beat_bytes) : base;

	always_comb begin
		case (mem_op)
			mem_lb, mem_lbu: size = 1;
			mem_lh, mem_lhu: size = 2;
			mem_lw: size = 4;
			default: size = 0;
		endcase
	end

	assign need_second_rd = ({1'b0, offset} + {1'b0, size}) > (beat_offset_width+1)'(beat_bytes);

	always_ff @(posedge clock) begin
		if (reset) begin
			beat_lo <= '0;
			beat_hi <= '0;
		end else if (capture_beat) begin
			if (second_beat) begin
				beat_hi <= rdata;
			end else begin
				beat_lo <= rdata;
			end
		end
	end

	// a load never reaches past the low word of the upper beat
	assign window = {beat_hi.halves[0], beat_lo};
	assign shifted = window >> {offset, 3'b000};
	assign raw = shifted[xlen-1:0];

	always_comb begin
		case (mem_op)
			mem_lb: load_data = {{(xlen-8){raw[7]}}, raw[7:0]};
			mem_lbu: load_data = {{(xlen-8){1'b0}}, raw[7:0]};
			mem_lh: load_data = {{(xlen-16){raw[15]}}, raw[15:0]};
			mem_lhu: load_data = {{(xlen-16){1'b0}}, raw[15:0]};
			default: load_data = raw;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/result_select.sv ====
`default_nettype none

module result_select (
	input wire done,
	input wire [exu_pkg::reg_addr_width-1:0] rd,
	input wire rf_wen_field,
	input wire exu_pkg::mem_op_t mem_op,
	input wire exu_pkg::jump_kind_t jump,
	input wire cond_branch,
	input wire [exu_pkg::xlen-1:0] branch_target,
	input wire [exu_pkg::xlen-1:0] pc,
	input wire [exu_pkg::xlen-1:0] alu_result,
	input wire [exu_pkg::xlen-1:0] load_data,
	output logic nextpc_valid,
	output logic nextpc_taken,
	output logic [exu_pkg::xlen-1:0] nextpc,
	output logic rf_wen,
	output logic [exu_pkg::reg_addr_width-1:0] rf_waddr,
	output logic [exu_pkg::xlen-1:0] rf_wdata
);
	import exu_pkg::*;

	logic cond_taken;

	// branch compare result sits in alu bit 0
	assign cond_taken = cond_branch && alu_result[0];
	assign nextpc_taken = (jump != jump_none) || cond_taken;
	assign nextpc_valid = done;

	always_comb begin
		if (jump == jump_jal) begin
			nextpc = alu_result;
		end else if (jump == jump_jalr) begin
			nextpc = {alu_result[xlen-1:1], 1'b0};
		end else if (cond_taken) begin
			nextpc = branch_target;
		end else begin
			nextpc = '0;
		end
	end

	assign rf_wen = done && rf_wen_field;
	assign rf_waddr = rd;

	// link address on jumps
	assign rf_wdata = (jump != jump_none) ? pc + xlen'(4) :
		is_load(mem_op) ? load_data : alu_result;

endmodule

`default_nettype wire

// ==== rtl/exu_ctrl.sv ====
`default_nettype none

module exu_ctrl (
	input wire clock,
	input wire reset,
	input wire in_valid,
	input wire exu_pkg::alu_op_t in_alu_op,
	input wire [exu_pkg::xlen-1:0] in_src1,
	input wire [exu_pkg::xlen-1:0] in_src2,
	input wire [exu_pkg::reg_addr_width-1:0] in_rd,
	input wire in_rf_wen,
	input wire exu_pkg::mem_op_t in_mem_op,
	input wire [exu_pkg::xlen-1:0] in_store_data,
	input wire [exu_pkg::xlen-1:0] in_pc,
	input wire exu_pkg::jump_kind_t in_jump,
	input wire in_cond_branch,
	input wire [exu_pkg::xlen-1:0] in_branch_target,
	input wire need_second_rd,
	input wire need_second_wr,
	input wire arready,
	input wire rvalid,
	input wire awready,
	input wire wready,
	input wire bvalid,
	output exu_pkg::alu_op_t alu_op,
	output logic [exu_pkg::xlen-1:0] src1,
	output logic [exu_pkg::xlen-1:0] src2,
	output logic [exu_pkg::reg_addr_width-1:0] rd,
	output logic rf_wen_field,
	output exu_pkg::mem_op_t mem_op,
	output logic [exu_pkg::xlen-1:0] store_data,
	output logic [exu_pkg::xlen-1:0] pc,
	output exu_pkg::jump_kind_t jump,
	output logic cond_branch,
	output logic [exu_pkg::xlen-1:0] branch_target,
	output logic second_beat,
	output logic capture_beat,
	output logic allowin,
	output logic done,
	output logic arvalid,
	output logic rready,
	output logic awvalid,
	output logic wvalid,
	output logic bready
);
	import exu_pkg::*;

	logic stage_valid;
	logic finish;
	logic mem_access;
	logic r_fire;
	logic b_fire;
	logic last_r;
	logic last_b;
	logic [1:0] rd_state;
	logic [1:0] rd_next;
	logic [2:0] wr_state;
	logic [2:0] wr_next;

	assign mem_access = is_load(mem_op) || is_store(mem_op);
	// non-memory ops finish in their first cycle in the stage
	assign done = stage_valid && (!mem_access || finish);
	assign allowin = !stage_valid || done;

	assign r_fire = rready && rvalid;
	assign b_fire = bready && bvalid;
	assign last_r = r_fire && (!need_second_rd || second_beat);
	assign last_b = b_fire && (!need_second_wr || second_beat);
	assign capture_beat = r_fire;

	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else if (allowin) begin
			stage_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && allowin) begin
			alu_op <= in_alu_op;
			src1 <= in_src1;
			src2 <= in_src2;
			rd <= in_rd;
			rf_wen_field <= in_rf_wen;
			mem_op <= in_mem_op;
			store_data <= in_store_data;
			pc <= in_pc;
			jump <= in_jump;
			cond_branch <= in_cond_branch;
			branch_target <= in_branch_target;
		end
	end

	// set on the last handshake, completion follows one cycle later
	always_ff @(posedge clock) begin
		if (reset || done) begin
			finish <= 1'b0;
		end else if (last_r || last_b) begin
			finish <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || done) begin
			second_beat <= 1'b0;
		end else if ((r_fire && !last_r) || (b_fire && !last_b)) begin
			second_beat <= 1'b1;
		end
	end

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			rd_idle: begin
				if (stage_valid && is_load(mem_op) && !finish) begin
					rd_next = rd_addr;
				end
			end
			rd_addr: begin
				if (arready) begin
					rd_next = rd_data;
				end
			end
			rd_data: begin
				if (r_fire) begin
					rd_next = last_r ? rd_idle : rd_second;
				end
			end
			rd_second: rd_next = rd_addr;
			default: rd_next = rd_idle;
		endcase
	end

	always_comb begin
		wr_next = wr_state;
		case (wr_state)
			wr_idle: begin
				if (stage_valid && is_store(mem_op) && !finish) begin
					wr_next = wr_addr;
				end
			end
			wr_addr: begin
				if (awready) begin
					wr_next = wr_data;
				end
			end
			wr_data: begin
				if (wready) begin
					wr_next = wr_resp;
				end
			end
			wr_resp: begin
				if (b_fire) begin
					wr_next = last_b ? wr_idle : wr_second;
				end
			end
			wr_second: wr_next = wr_addr;
			default: wr_next = wr_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_state <= rd_idle;
			wr_state <= wr_idle;
		end else begin
			rd_state <= rd_next;
			wr_state <= wr_next;
		end
	end

	// channel handshakes straight from the state registers
	assign arvalid = rd_state == rd_addr;
	assign rready = rd_state == rd_data;
	assign awvalid = wr_state == wr_addr;
	assign wvalid = wr_state == wr_data;
	assign bready = wr_state == wr_resp;

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`default_nettype none

module exu_top (
	input wire clock,
	input wire reset,
	input wire in_valid,
	input wire exu_pkg::alu_op_t in_alu_op,
	input wire [exu_pkg::xlen-1:0] in_src1,
	input wire [exu_pkg::xlen-1:0] in_src2,
	input wire [exu_pkg::reg_addr_width-1:0] in_rd,
	input wire in_rf_wen,
	input wire exu_pkg::mem_op_t in_mem_op,
	input wire [exu_pkg::xlen-1:0] in_store_data,
	input wire [exu_pkg::xlen-1:0] in_pc,
	input wire exu_pkg::jump_kind_t in_jump,
	input wire in_cond_branch,
	input wire [exu_pkg::xlen-1:0] in_branch_target,
	output logic allowin,
	output logic nextpc_valid,
	output logic nextpc_taken,
	output logic [exu_pkg::xlen-1:0] nextpc,
	output logic rf_wen,
	output logic [exu_pkg::reg_addr_width-1:0] rf_waddr,
	output logic [exu_pkg::xlen-1:0] rf_wdata,
	output logic awvalid,
	input wire awready,
	output logic [exu_pkg::xlen-1:0] awaddr,
	output logic wvalid,
	input wire wready,
	output logic [exu_pkg::beat_width-1:0] wdata,
	output logic [exu_pkg::beat_bytes-1:0] wstrb,
	input wire bvalid,
	output logic bready,
	output logic arvalid,
	input wire arready,
	output logic [exu_pkg::xlen-1:0] araddr,
	input wire rvalid,
	output logic rready,
	input wire [exu_pkg::beat_width-1:0] rdata
);
	import exu_pkg::*;

	alu_op_t alu_op;
	mem_op_t mem_op;
	jump_kind_t jump;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic [reg_addr_width-1:0] rd;
	logic rf_wen_field;
	logic [xlen-1:0] store_data;
	logic [xlen-1:0] pc;
	logic cond_branch;
	logic [xlen-1:0] branch_target;
	logic second_beat;
	logic capture_beat;
	logic done;
	logic need_second_rd;
	logic need_second_wr;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] load_data;

	exu_ctrl u_ctrl (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_alu_op(in_alu_op),
		.in_src1(in_src1),
		.in_src2(in_src2),
		.in_rd(in_rd),
		.in_rf_wen(in_rf_wen),
		.in_mem_op(in_mem_op),
		.in_store_data(in_store_data),
		.in_pc(in_pc),
		.in_jump(in_jump),
		.in_cond_branch(in_cond_branch),
		.in_branch_target(in_branch_target),
		.need_second_rd(need_second_rd),
		.need_second_wr(need_second_wr),
		.arready(arready),
		.rvalid(rvalid),
		.awready(awready),
		.wready(wready),
		.bvalid(bvalid),
		.alu_op(alu_op),
		.src1(src1),
		.src2(src2),
		.rd(rd),
		.rf_wen_field(rf_wen_field),
		.mem_op(mem_op),
		.store_data(store_data),
		.pc(pc),
		.jump(jump),
		.cond_branch(cond_branch),
		.branch_target(branch_target),
		.second_beat(second_beat),
		.capture_beat(capture_beat),
		.allowin(allowin),
		.done(done),
		.arvalid(arvalid),
		.rready(rready),
		.awvalid(awvalid),
		.wvalid(wvalid),
		.bready(bready)
	);

	exu_alu u_alu (
		.alu_op(alu_op),
		.src1(src1),
		.src2(src2),
		.result(alu_result)
	);

	// the alu result doubles as the memory address
	store_align u_store_align (
		.mem_op(mem_op),
		.addr(alu_result),
		.store_data(store_data),
		.second_beat(second_beat),
		.awaddr(awaddr),
		.wdata(wdata),
		.wstrb(wstrb),
		.need_second_wr(need_second_wr)
	);

	load_align u_load_align (
		.clock(clock),
		.reset(reset),
		.mem_op(mem_op),
		.addr(alu_result),
		.second_beat(second_beat),
		.capture_beat(capture_beat),
		.rdata(rdata),
		.araddr(araddr),
		.need_second_rd(need_second_rd),
		.load_data(load_data)
	);

	result_select u_result_select (
		.done(done),
		.rd(rd),
		.rf_wen_field(rf_wen_field),
		.mem_op(mem_op),
		.jump(jump),
		.cond_branch(cond_branch),
		.branch_target(branch_target),
		.pc(pc),
		.alu_result(alu_result),
		.load_data(load_data),
		.nextpc_valid(nextpc_valid),
		.nextpc_taken(nextpc_taken),
		.nextpc(nextpc),
		.rf_wen(rf_wen),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata)
	);

endmodule

`default_nettype wire

// ==== bench/data_mem_model.sv ====
`default_nettype none

module data_mem_model (
	input wire clock,
	input wire reset,
	input wire awvalid,
	output logic awready,
	input wire [exu_pkg::xlen-1:0] awaddr,
	input wire wvalid,
	output logic wready,
	input wire [exu_pkg::beat_width-1:0] wdata,
	input wire [exu_pkg::beat_bytes-1:0] wstrb,
	output logic bvalid,
	input wire bready,
	input wire arvalid,
	output logic arready,
	input wire [exu_pkg::xlen-1:0] araddr,
	output logic rvalid,
	input wire rready,
	output logic [exu_pkg::beat_width-1:0] rdata
);
	logic [7:0] bytes [512];
	// write beats seen per aligned beat address
	int write_beats [64];
	logic [8:0] rd_base;
	logic [8:0] wr_base;
	logic r_due;
	logic b_due;
	int ar_wait;
	int r_wait;
	int aw_wait;
	int w_wait;
	int b_wait;

	function automatic logic [63:0] read_beat(logic [8:0] base);
		logic [63:0] v;
		for (int k = 0; k < 8; k++) begin
			v[8*k +: 8] = bytes[9'(base + k)];
		end
		return v;
	endfunction

	initial begin
		for (int i = 0; i < 512; i++) begin
			bytes[i] = 8'((i * 29) ^ (i >> 8) ^ 8'ha5);
		end
		for (int i = 0; i < 64; i++) begin
			write_beats[i] = 0;
		end
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		r_due = 1'b0;
		b_due = 1'b0;
		ar_wait = 0;
		r_wait = 0;
		aw_wait = 0;
		w_wait = 0;
		b_wait = 0;
	end

	// read address accepted first and data after a random delay
	always @(posedge clock) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			r_due <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				arready <= 1'b0;
				rd_base <= {araddr[8:3], 3'b000};
				r_due <= 1'b1;
				r_wait <= $urandom % 4;
				ar_wait <= $urandom % 4;
			end else if (arvalid && !arready) begin
				if (ar_wait == 0) begin
					arready <= 1'b1;
				end else begin
					ar_wait <= ar_wait - 1;
				end
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				r_due <= 1'b0;
			end else if (r_due && !rvalid) begin
				if (r_wait == 0) begin
					rvalid <= 1'b1;
					rdata <= read_beat(rd_base);
				end else begin
					r_wait <= r_wait - 1;
				end
			end
		end
	end

	// write address first, data with strobes next and the response last
	always @(posedge clock) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			b_due <= 1'b0;
		end else begin
			if (awvalid && awready) begin
				awready <= 1'b0;
				wr_base <= {awaddr[8:3], 3'b000};
				aw_wait <= $urandom % 4;
			end else if (awvalid && !awready) begin
				if (aw_wait == 0) begin
					awready <= 1'b1;
				end else begin
					aw_wait <= aw_wait - 1;
				end
			end
			if (wvalid && wready) begin
				wready <= 1'b0;
				for (int k = 0; k < 8; k++) begin
					if (wstrb[k]) begin
						bytes[9'(wr_base + k)] <= wdata[8*k +: 8];
					end
				end
				write_beats[wr_base[8:3]] <= write_beats[wr_base[8:3]] + 1;
				b_due <= 1'b1;
				b_wait <= $urandom % 4;
				w_wait <= $urandom % 4;
			end else if (wvalid && !wready) begin
				if (w_wait == 0) begin
					wready <= 1'b1;
				end else begin
					w_wait <= w_wait - 1;
				end
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				b_due <= 1'b0;
			end else if (b_due && !bvalid) begin
				if (b_wait == 0) begin
					bvalid <= 1'b1;
				end else begin
					b_wait <= b_wait - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_exu.sv ====
`default_nettype none

module tb_exu;
	import exu_pkg::*;

	localparam int num_instr = 400;
	localparam int timeout_cycles = num_instr * 60;
	localparam int mem_bytes = 512;

	logic clock;
	logic reset;
	logic in_valid;
	alu_op_t in_alu_op;
	logic [xlen-1:0] in_src1;
	logic [xlen-1:0] in_src2;
	logic [reg_addr_width-1:0] in_rd;
	logic in_rf_wen;
	mem_op_t in_mem_op;
	logic [xlen-1:0] in_store_data;
	logic [xlen-1:0] in_pc;
	jump_kind_t in_jump;
	logic in_cond_branch;
	logic [xlen-1:0] in_branch_target;
	logic allowin;
	logic nextpc_valid;
	logic nextpc_taken;
	logic [xlen-1:0] nextpc;
	logic rf_wen;
	logic [reg_addr_width-1:0] rf_waddr;
	logic [xlen-1:0] rf_wdata;
	logic awvalid;
	logic awready;
	logic [xlen-1:0] awaddr;
	logic wvalid;
	logic wready;
	logic [beat_width-1:0] wdata;
	logic [beat_bytes-1:0] wstrb;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic [xlen-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [beat_width-1:0] rdata;

	// expected outcome of each accepted instruction in order
	logic exp_taken [num_instr];
	logic [xlen-1:0] exp_nextpc [num_instr];
	logic exp_wen [num_instr];
	logic [reg_addr_width-1:0] exp_waddr [num_instr];
	logic [xlen-1:0] exp_wdata [num_instr];
	logic exp_mem [num_instr];
	int exp_cycle [num_instr];
	int exp_beats [num_instr];
	logic [xlen-1:0] exp_base [num_instr];
	logic [15:0] exp_mask [num_instr];
	logic [7:0] ref_mem [mem_bytes];
	int beats_at [mem_bytes/8];
	logic [xlen-1:0] aw_seen [4];
	logic [7:0] strb_seen [4];
	int aw_n;
	int w_n;
	int accepted;
	int completed;
	int cycle;
	int errors;
	int seed_value;
	logic holding;
	logic p_arvalid;
	logic p_arready;
	logic p_awvalid;
	logic p_awready;
	logic p_wvalid;
	logic p_wready;
	logic [xlen-1:0] p_araddr;
	logic [xlen-1:0] p_awaddr;
	logic [beat_width-1:0] p_wdata;
	logic [7:0] p_wstrb;

	exu_top uut (
		.clock(clock), .reset(reset), .in_valid(in_valid),
		.in_alu_op(in_alu_op), .in_src1(in_src1), .in_src2(in_src2),
		.in_rd(in_rd), .in_rf_wen(in_rf_wen), .in_mem_op(in_mem_op),
		.in_store_data(in_store_data), .in_pc(in_pc), .in_jump(in_jump),
		.in_cond_branch(in_cond_branch), .in_branch_target(in_branch_target),
		.allowin(allowin), .nextpc_valid(nextpc_valid), .nextpc_taken(nextpc_taken),
		.nextpc(nextpc), .rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata)
	);

	data_mem_model data_mem (
		.clock(clock), .reset(reset),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		#(timeout_cycles * 10);
		$display("timeout: the instruction stream did not finish in %0d cycles", timeout_cycles);
		$display("errors: %0d, completed: %0d of %0d", errors + 1, completed, num_instr);
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic logic [7:0] fill_byte(int i);
		return 8'((i * 29) ^ (i >> 8) ^ 8'ha5);
	endfunction

	function automatic logic [xlen-1:0] alu_ref(alu_op_t op, logic [xlen-1:0] a,
			logic [xlen-1:0] b);
		case (op)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			alu_or: return a | b;
			alu_xor: return a ^ b;
			alu_sll: return a << b[4:0];
			alu_srl: return a >> b[4:0];
			alu_sra: return $signed(a) >>> b[4:0];
			alu_slt: return ($signed(a) < $signed(b)) ? 1 : 0;
			alu_sltu: return (a < b) ? 1 : 0;
			alu_eq: return (a == b) ? 1 : 0;
			alu_ne: return (a != b) ? 1 : 0;
			alu_ge: return ($signed(a) >= $signed(b)) ? 1 : 0;
			alu_geu: return (a >= b) ? 1 : 0;
			default: return 0;
		endcase
	endfunction

	function automatic int access_size(mem_op_t op);
		case (op)
			mem_lb, mem_lbu, mem_sb: return 1;
			mem_lh, mem_lhu, mem_sh: return 2;
			default: return 4;
		endcase
	endfunction

	// little endian bytes with sign or zero extension
	function automatic logic [xlen-1:0] load_ref(mem_op_t op, logic [xlen-1:0] addr);
		logic [xlen-1:0] v;
		v = '0;
		for (int k = 0; k < access_size(op); k++) begin
			v[8*k +: 8] = ref_mem[(addr + k) % mem_bytes];
		end
		case (op)
			mem_lb: v = {{24{v[7]}}, v[7:0]};
			mem_lh: v = {{16{v[15]}}, v[15:0]};
			default: ;
		endcase
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
			$time, name, expected, actual);
		errors++;
	endtask

	task automatic make_instr();
		int kind;
		kind = $urandom % 4;
		in_alu_op = alu_add;
		in_src1 = $urandom;
		in_src2 = $urandom;
		in_rd = $urandom;
		in_rf_wen = 1'b1;
		in_mem_op = mem_none;
		in_store_data = $urandom;
		in_pc = $urandom & ~32'h3;
		in_jump = jump_none;
		in_cond_branch = 1'b0;
		in_branch_target = $urandom & ~32'h3;
		if (kind == 0) begin
			in_alu_op = alu_op_t'(4'($urandom % 14));
			in_rf_wen = $urandom % 2;
		end else if (kind == 1 || kind == 2) begin
			// 256-byte window with any byte offset in the beat
			in_src1 = ($urandom % 32) * 8;
			in_src2 = $urandom % 8;
			if (kind == 1) begin
				in_mem_op = mem_op_t'(4'(1 + $urandom % 5));
			end else begin
				in_mem_op = mem_op_t'(4'(6 + $urandom % 3));
				in_rf_wen = 1'b0;
			end
		end else begin
			case ($urandom % 3)
				0: begin
					in_jump = jump_jal;
					in_src1 = in_pc;
					in_src2 = $urandom & 32'h000f_fffe;
				end
				1: in_jump = jump_jalr;
				default: begin
					in_alu_op = alu_op_t'(4'(8 + $urandom % 6));
					in_cond_branch = 1'b1;
					in_rf_wen = 1'b0;
					if ($urandom % 2) begin
						in_src2 = in_src1;
					end
				end
			endcase
		end
	endtask

	task automatic record_expected();
		logic [xlen-1:0] res;
		logic [15:0] mask;
		int size;
		res = alu_ref(in_alu_op, in_src1, in_src2);
		size = access_size(in_mem_op);
		exp_cycle[accepted] = cycle;
		exp_mem[accepted] = in_mem_op != mem_none;
		exp_wen[accepted] = in_rf_wen;
		exp_waddr[accepted] = in_rd;
		exp_taken[accepted] = (in_jump != jump_none) || (in_cond_branch && res[0]);
		if (in_jump == jump_jal) begin
			exp_nextpc[accepted] = res;
		end else if (in_jump == jump_jalr) begin
			exp_nextpc[accepted] = res & ~32'h1;
		end else if (in_cond_branch && res[0]) begin
			exp_nextpc[accepted] = in_branch_target;
		end else begin
			exp_nextpc[accepted] = '0;
		end
		if (in_jump != jump_none) begin
			exp_wdata[accepted] = in_pc + 4;
		end else if (is_load(in_mem_op)) begin
			exp_wdata[accepted] = load_ref(in_mem_op, res);
		end else begin
			exp_wdata[accepted] = res;
		end
		mask = '0;
		exp_beats[accepted] = 0;
		if (is_store(in_mem_op)) begin
			// bytes 8..15 of the mask belong to the beat above
			mask = 16'(((1 << size) - 1) << res[2:0]);
			exp_beats[accepted] = (mask[15:8] != 0) ? 2 : 1;
			for (int k = 0; k < size; k++) begin
				ref_mem[(res + k) % mem_bytes] = in_store_data[8*k +: 8];
			end
			beats_at[res[8:3]]++;
			if (mask[15:8] != 0) begin
				beats_at[res[8:3] + 1]++;
			end
		end
		exp_mask[accepted] = mask;
		exp_base[accepted] = {res[xlen-1:3], 3'b000};
		accepted++;
	endtask

	task automatic watch_channels();
		if (p_arvalid && !p_arready && (!arvalid || araddr !== p_araddr)) begin
			$display("%0t: arvalid dropped or araddr changed before arready", $time);
			errors++;
		end
		if (p_awvalid && !p_awready && (!awvalid || awaddr !== p_awaddr)) begin
			$display("%0t: awvalid dropped or awaddr changed before awready", $time);
			errors++;
		end
		if (p_wvalid && !p_wready && (!wvalid || wdata !== p_wdata || wstrb !== p_wstrb)) begin
			$display("%0t: wvalid dropped or write data changed before wready", $time);
			errors++;
		end
		if (allowin && (arvalid || rready || awvalid || wvalid || bready)) begin
			$display("%0t: allowin is high while a memory access is pending", $time);
			errors++;
		end
		if (rf_wen && !nextpc_valid) begin
			$display("%0t: rf_wen is high outside a completion cycle", $time);
			errors++;
		end
		// handshakes that happen at the coming edge
		if (awvalid && awready && aw_n < 4) begin
			aw_seen[aw_n] = awaddr;
			aw_n++;
		end
		if (wvalid && wready && w_n < 4) begin
			strb_seen[w_n] = wstrb;
			w_n++;
		end
		p_arvalid = arvalid;
		p_arready = arready;
		p_araddr = araddr;
		p_awvalid = awvalid;
		p_awready = awready;
		p_awaddr = awaddr;
		p_wvalid = wvalid;
		p_wready = wready;
		p_wdata = wdata;
		p_wstrb = wstrb;
	endtask

	task automatic check_completion();
		int idx;
		idx = completed;
		if (idx >= accepted) begin
			$display("%0t: nextpc_valid pulsed with no instruction pending", $time);
			errors++;
		end else begin
			if (nextpc_taken !== exp_taken[idx]) begin
				report_mismatch("nextpc_taken", exp_taken[idx], nextpc_taken);
			end
			if (nextpc !== exp_nextpc[idx]) begin
				report_mismatch("nextpc", exp_nextpc[idx], nextpc);
			end
			if (rf_wen !== exp_wen[idx]) begin
				report_mismatch("rf_wen", exp_wen[idx], rf_wen);
			end
			if (exp_wen[idx] && rf_waddr !== exp_waddr[idx]) begin
				report_mismatch("rf_waddr", exp_waddr[idx], rf_waddr);
			end
			if (exp_wen[idx] && rf_wdata !== exp_wdata[idx]) begin
				report_mismatch("rf_wdata", exp_wdata[idx], rf_wdata);
			end
			if (!exp_mem[idx] && cycle != exp_cycle[idx] + 1) begin
				$display("%0t: instruction %0d did not complete one cycle after acceptance",
					$time, idx);
				errors++;
			end
			if (aw_n != exp_beats[idx]) begin
				report_mismatch("awvalid beats", exp_beats[idx], aw_n);
			end
			if (w_n != exp_beats[idx]) begin
				report_mismatch("wvalid beats", exp_beats[idx], w_n);
			end
			for (int b = 0; b < aw_n && b < w_n && b < exp_beats[idx]; b++) begin
				if (aw_seen[b] !== exp_base[idx] + 8 * b) begin
					report_mismatch("awaddr", exp_base[idx] + 8 * b, aw_seen[b]);
				end
				if (strb_seen[b] !== exp_mask[idx][8*b +: 8]) begin
					report_mismatch("wstrb", exp_mask[idx][8*b +: 8], strb_seen[b]);
				end
			end
			completed++;
		end
		aw_n = 0;
		w_n = 0;
	endtask

	task automatic drive_inputs();
		if (!holding) begin
			if (accepted < num_instr && ($urandom % 4) != 0) begin
				make_instr();
				in_valid = 1'b1;
			end else begin
				in_valid = 1'b0;
			end
		end
		// allowin already holds its value for the coming edge
		if (in_valid && allowin) begin
			record_expected();
			holding = 1'b0;
		end else begin
			holding = in_valid;
		end
	endtask

	initial begin
		seed_value = $urandom(5);
		reset = 1'b1;
		in_valid = 1'b0;
		in_alu_op = alu_add;
		in_src1 = '0;
		in_src2 = '0;
		in_rd = '0;
		in_rf_wen = 1'b0;
		in_mem_op = mem_none;
		in_store_data = '0;
		in_pc = '0;
		in_jump = jump_none;
		in_cond_branch = 1'b0;
		in_branch_target = '0;
		accepted = 0;
		completed = 0;
		cycle = 0;
		errors = 0;
		aw_n = 0;
		w_n = 0;
		holding = 1'b0;
		p_arvalid = 1'b0;
		p_awvalid = 1'b0;
		p_wvalid = 1'b0;
		for (int i = 0; i < mem_bytes; i++) begin
			ref_mem[i] = fill_byte(i);
		end
		for (int i = 0; i < mem_bytes / 8; i++) begin
			beats_at[i] = 0;
		end
		repeat (8) @(negedge clock);
		reset = 1'b0;
		while (completed < num_instr) begin
			@(negedge clock);
			cycle++;
			watch_channels();
			if (nextpc_valid) begin
				check_completion();
			end
			drive_inputs();
		end
		// beats the memory saw per aligned address
		for (int i = 0; i < mem_bytes / 8; i++) begin
			if (data_mem.write_beats[i] != beats_at[i]) begin
				report_mismatch($sformatf("write_beats[%0d]", i), beats_at[i],
					data_mem.write_beats[i]);
			end
		end
		// stored bytes as the memory holds them at the end
		for (int i = 0; i < mem_bytes; i++) begin
			if (data_mem.bytes[i] !== ref_mem[i]) begin
				report_mismatch($sformatf("bytes[%0d]", i), ref_mem[i], data_mem.bytes[i]);
			end
		end
		$display("errors: %0d, completed: %0d of %0d", errors, completed, num_instr);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/store_align.sv
rtl/load_align.sv
rtl/result_select.sv
rtl/exu_ctrl.sv
rtl/exu_top.sv
bench/data_mem_model.sv
bench/tb_exu.sv

// ==== Bender.yml ====
package:
  name: exu

sources:
  - rtl/exu_pkg.sv
  - rtl/exu_alu.sv
  - rtl/store_align.sv
  - rtl/load_align.sv
  - rtl/result_select.sv
  - rtl/exu_ctrl.sv
  - rtl/exu_top.sv
  - target: test
    files:
      - bench/data_mem_model.sv
      - bench/tb_exu.sv
